/* common/rv_pkg.sv */
package rv_pkg;

    // basic data and address word
    typedef logic [31:0] word_t;

    // register index, x0..x31
    typedef logic [4:0] reg_addr_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // funct3 of the ALU groups
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 of the branch group
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // alu operations, top bit marks the alternate form
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SLL    = 4'b0001,
        ALU_SLT    = 4'b0010,
        ALU_SLTU   = 4'b0011,
        ALU_XOR    = 4'b0100,
        ALU_SRL    = 4'b0101,
        ALU_OR     = 4'b0110,
        ALU_AND    = 4'b0111,
        ALU_SUB    = 4'b1000,
        ALU_SRA    = 4'b1101,
        ALU_PASS_B = 4'b1111
    } alu_op_e;

    // immediate formats
    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } imm_fmt_e;

    // first alu operand
    typedef enum logic {
        A_REG = 1'b0,
        A_PC  = 1'b1
    } alu_a_sel_e;

    // second alu operand
    typedef enum logic [1:0] {
        B_REG  = 2'd0,
        B_IMM  = 2'd1,
        B_FOUR = 2'd2
    } alu_b_sel_e;

    // r-format view
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_e    opcode;
    } r_fmt_t;

    // i-format view
    typedef struct packed {
        logic [11:0] imm12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_e     opcode;
    } i_fmt_t;

    // same instruction word seen two ways
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

/* hdl/alu.sv */
module alu (
    input  rv_pkg::alu_op_e alu_op,
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    output rv_pkg::word_t   result,
    output logic            lt,
    output logic            zero
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // shifts use the low five bits only
    assign shamt = b[4:0];

    // both compares, picked by the op
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    // unsigned only for sltu, signed otherwise
    assign lt = (alu_op == ALU_SLTU) ? lt_unsigned : lt_signed;

    always_comb begin
        case (alu_op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = {31'b0, lt};
            ALU_SLTU:   result = {31'b0, lt};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA:    result = $signed(a) >>> shamt;
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            // lui passes the immediate through
            ALU_PASS_B: result = b;
            default:    result = a + b;
        endcase
    end

    // beq/bne look at the sub result
    assign zero = (result == 32'd0);

endmodule

/* hdl/imm_decoder.sv */
module imm_decoder (
    input  rv_pkg::instr_u   instr,
    input  rv_pkg::imm_fmt_e imm_fmt,
    output rv_pkg::word_t    imm
);
    import rv_pkg::*;

    word_t w;
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    // raw bits for the scattered formats
    assign w = instr;

    // i-type straight from the i view
    assign imm_i = {{20{instr.i.imm12[11]}}, instr.i.imm12};

    // s-type, split around rd
    assign imm_s = {{20{w[31]}}, w[31:25], w[11:7]};

    // b-type, always even
    assign imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};

    // u-type, low 12 bits zero
    assign imm_u = {w[31:12], 12'b0};

    // j-type, 21-bit signed offset
    assign imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};

    always_comb begin
        case (imm_fmt)
            IMM_S:   imm = imm_s;
            IMM_B:   imm = imm_b;
            IMM_U:   imm = imm_u;
            IMM_J:   imm = imm_j;
            default: imm = imm_i;
        endcase
    end

endmodule

/* hdl/reg_file.sv */
module reg_file (
    input  logic              clk,
    input  rv_pkg::reg_addr_t raddr_a,
    input  rv_pkg::reg_addr_t raddr_b,
    input  rv_pkg::reg_addr_t waddr,
    input  rv_pkg::word_t     wdata,
    input  logic              we,
    output rv_pkg::word_t     rdata_a,
    output rv_pkg::word_t     rdata_b
);
    import rv_pkg::*;

    // x1..x31, x0 has no storage
    word_t regs [1:31];

    // write on the edge, x0 dropped here
    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // port a, combinational
    always_comb begin
        if (raddr_a == 5'd0) begin
            rdata_a = '0;
        end else begin
            rdata_a = regs[raddr_a];
        end
    end

    // port b, combinational
    always_comb begin
        if (raddr_b == 5'd0) begin
            rdata_b = '0;
        end else begin
            rdata_b = regs[raddr_b];
        end
    end

    // a write shows up on reads from the next cycle on

endmodule

/* hdl/control_unit.sv */
module control_unit (
    input  rv_pkg::instr_u     instr,
    input  logic               lt,
    input  logic               zero,
    output rv_pkg::alu_op_e    alu_op,
    output rv_pkg::imm_fmt_e   imm_fmt,
    output rv_pkg::alu_a_sel_e alu_a_sel,
    output rv_pkg::alu_b_sel_e alu_b_sel,
    output logic               reg_we,
    output logic               pc_base_sel,
    output logic               pc_off_sel
);
    import rv_pkg::*;

    logic [2:0] funct3;
    logic       is_branch;
    logic       taken;

    // funct3 sits in the same place in both views
    assign funct3 = instr.r.funct3;

    // funct3 plus alternate bit to alu op
    function automatic alu_op_e decode_alu(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // datapath selects, from the instruction only
    always_comb begin
        alu_op      = ALU_ADD;
        imm_fmt     = IMM_I;
        alu_a_sel   = A_REG;
        alu_b_sel   = B_REG;
        reg_we      = 1'b0;
        pc_base_sel = 1'b0;
        is_branch   = 1'b0;
        case (instr.r.opcode)
            OPC_OP: begin
                reg_we = 1'b1;
                alu_op = decode_alu(funct3, instr.r.funct7[5]);
            end
            OPC_OP_IMM: begin
                reg_we    = 1'b1;
                alu_b_sel = B_IMM;
                // only srai has an alternate form, addi never subtracts
                alu_op    = decode_alu(funct3, (funct3 == F3_SR) && instr.i.imm12[10]);
            end
            OPC_LUI: begin
                reg_we    = 1'b1;
                imm_fmt   = IMM_U;
                alu_b_sel = B_IMM;
                alu_op    = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                reg_we    = 1'b1;
                imm_fmt   = IMM_U;
                alu_a_sel = A_PC;
                alu_b_sel = B_IMM;
            end
            OPC_JAL: begin
                // link value pc + 4
                reg_we    = 1'b1;
                imm_fmt   = IMM_J;
                alu_a_sel = A_PC;
                alu_b_sel = B_FOUR;
            end
            OPC_JALR: begin
                reg_we      = 1'b1;
                alu_a_sel   = A_PC;
                alu_b_sel   = B_FOUR;
                pc_base_sel = 1'b1;
            end
            OPC_BRANCH: begin
                imm_fmt   = IMM_B;
                is_branch = 1'b1;
                // compare rs1 with rs2
                case (funct3)
                    F3_BLT, F3_BGE:   alu_op = ALU_SLT;
                    F3_BLTU, F3_BGEU: alu_op = ALU_SLTU;
                    default:          alu_op = ALU_SUB;
                endcase
            end
            default: begin
                // unknown opcode falls through as a nop
            end
        endcase
    end

    // branch decision, kept apart from the selects feeding the alu
    always_comb begin
        case (funct3)
            F3_BEQ:  taken = zero;
            F3_BNE:  taken = !zero;
            F3_BLT:  taken = lt;
            F3_BGE:  taken = !lt;
            F3_BLTU: taken = lt;
            F3_BGEU: taken = !lt;
            default: taken = 1'b0;
        endcase
    end

    // offset is the immediate for jumps and taken branches
    assign pc_off_sel = (instr.r.opcode == OPC_JAL) || (instr.r.opcode == OPC_JALR) ||
                        (is_branch && taken);

endmodule

/* hdl/pc_unit.sv */
module pc_unit #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic          clk,
    input  logic          rst_n,
    input  rv_pkg::word_t base,
    input  rv_pkg::word_t offset,
    input  logic          clear_lsb,
    output rv_pkg::word_t pc
);
    import rv_pkg::*;

    word_t sum;
    word_t next_pc;

    // base + offset
    assign sum = base + offset;

    // jalr drops bit 0 of the target
    assign next_pc = clear_lsb ? {sum[31:1], 1'b0} : sum;

    // updates every cycle, no stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

/* hdl/cpu_core.sv */
module cpu_core #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::word_t     instr,
    output rv_pkg::word_t     pc,
    output logic              retire_we,
    output rv_pkg::reg_addr_t retire_rd,
    output rv_pkg::word_t     retire_data
);
    import rv_pkg::*;

    instr_u     instr_w;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm;
    word_t      alu_a;
    word_t      alu_b;
    word_t      alu_result;
    word_t      pc_base;
    word_t      pc_offset;
    alu_op_e    alu_op;
    imm_fmt_e   imm_fmt;
    alu_a_sel_e alu_a_sel;
    alu_b_sel_e alu_b_sel;
    logic       reg_we;
    logic       pc_base_sel;
    logic       pc_off_sel;
    logic       lt;
    logic       zero;
    logic       wb_we;

    // fetched word, register fields from the r view
    assign instr_w = instr;
    assign rs1     = instr_w.r.rs1;
    assign rs2     = instr_w.r.rs2;
    assign rd      = instr_w.r.rd;

    control_unit u_ctrl (
        .instr       (instr_w),
        .lt          (lt),
        .zero        (zero),
        .alu_op      (alu_op),
        .imm_fmt     (imm_fmt),
        .alu_a_sel   (alu_a_sel),
        .alu_b_sel   (alu_b_sel),
        .reg_we      (reg_we),
        .pc_base_sel (pc_base_sel),
        .pc_off_sel  (pc_off_sel)
    );

    imm_decoder u_imm (
        .instr   (instr_w),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    // no writeback while reset is held
    assign wb_we = reg_we && rst_n;

    reg_file u_rf (
        .clk     (clk),
        .raddr_a (rs1),
        .raddr_b (rs2),
        .waddr   (rd),
        .wdata   (alu_result),
        .we      (wb_we),
        .rdata_a (rs1_data),
        .rdata_b (rs2_data)
    );

    // operand a, rs1 or pc
    assign alu_a = (alu_a_sel == A_PC) ? pc : rs1_data;

    // operand b, rs2, immediate or four for the link
    always_comb begin
        case (alu_b_sel)
            B_IMM:   alu_b = imm;
            B_FOUR:  alu_b = 32'd4;
            default: alu_b = rs2_data;
        endcase
    end

    alu u_alu (
        .alu_op (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .lt     (lt),
        .zero   (zero)
    );

    // next pc, base is rs1 only for jalr
    assign pc_base   = pc_base_sel ? rs1_data : pc;
    assign pc_offset = pc_off_sel ? imm : 32'd4;

    pc_unit #(
        .RESET_PC (RESET_PC)
    ) u_pc (
        .clk       (clk),
        .rst_n     (rst_n),
        .base      (pc_base),
        .offset    (pc_offset),
        .clear_lsb (pc_base_sel),
        .pc        (pc)
    );

    // retire trace mirrors the register write port
    assign retire_we   = wb_we;
    assign retire_rd   = rd;
    assign retire_data = alu_result;

endmodule

/* test/cpu_core_checker.sv */
module cpu_core_checker #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input logic              clk,
    input logic              rst_n,
    input rv_pkg::word_t     pc,
    input logic              retire_we,
    input rv_pkg::reg_addr_t rs1,
    input rv_pkg::word_t     rs1_data,
    input rv_pkg::reg_addr_t rs2,
    input rv_pkg::word_t     rs2_data
);

    // fetch address stays on a word boundary
    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("pc %h is not word aligned", pc);

    // nothing retires while reset is held
    no_retire_in_reset: assert property (@(posedge clk) !rst_n |-> !retire_we)
        else $error("retire_we high during reset");

    // first fetch after reset comes from the reset vector
    reset_vector: assert property (@(posedge clk) !rst_n |=> pc == RESET_PC)
        else $error("pc %h after reset, expected %h", pc, RESET_PC);

    // x0 keeps reading zero, whatever was written to it
    x0_zero_a: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1 == 5'd0) |-> (rs1_data == 32'd0))
        else $error("x0 read as %h on port a", rs1_data);

    x0_zero_b: assert property (@(posedge clk) disable iff (!rst_n)
        (rs2 == 5'd0) |-> (rs2_data == 32'd0))
        else $error("x0 read as %h on port b", rs2_data);

endmodule

// attach to every core instance
bind cpu_core cpu_core_checker #(
    .RESET_PC (RESET_PC)
) u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .pc        (pc),
    .retire_we (retire_we),
    .rs1       (rs1),
    .rs1_data  (rs1_data),
    .rs2       (rs2),
    .rs2_data  (rs2_data)
);

/* test/cpu_core_tb.sv */
module cpu_core_tb;
    import rv_pkg::*;

    localparam word_t       START_PC        = 32'h0000_0100;
    localparam int          CLK_PERIOD      = 40;
    localparam int          RESET_CYCLES    = 5;
    localparam int          WATCHDOG_MARGIN = 400;
    localparam logic [31:0] SEED            = 32'h92201d10;

    logic      clk;
    logic      rst_n;
    word_t     instr;
    word_t     pc;
    logic      retire_we;
    reg_addr_t retire_rd;
    word_t     retire_data;

    // one entry per executed instruction
    string     names[$];
    word_t     instrs[$];
    word_t     pcs[$];
    logic      wes[$];
    reg_addr_t rds[$];
    word_t     datas[$];

    // architectural registers as the table expects them
    word_t     xr [32];
    word_t     cur_pc;
    logic      table_ready;
    int        test_errs;
    int        tests_run;
    int        tests_failed;

    cpu_core #(
        .RESET_PC (START_PC)
    ) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .pc          (pc),
        .retire_we   (retire_we),
        .retire_rd   (retire_rd),
        .retire_data (retire_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // instruction encoders
    function automatic word_t r_word(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3,
                                     input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t i_word(input logic [11:0] imm, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t rd,
                                     input opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t u_word(input logic [19:0] imm, input reg_addr_t rd,
                                     input opcode_e op);
        return {imm, rd, op};
    endfunction

    // offset bits scattered around rs1/rs2
    function automatic word_t branch_word(input logic [12:0] off, input reg_addr_t rs1,
                                          input reg_addr_t rs2, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t jal_word(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // reference rules
    function automatic word_t sign_ext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic word_t sign_ext13(input logic [12:0] v);
        return {{19{v[12]}}, v};
    endfunction

    function automatic word_t sign_ext21(input logic [20:0] v);
        return {{11{v[20]}}, v};
    endfunction

    // sign bits copied into the top half and then a logical shift
    function automatic word_t shift_right_arith(input word_t v, input logic [4:0] sh);
        logic [63:0] wide;
        wide = {{32{v[31]}}, v} >> sh;
        return wide[31:0];
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // append one row running at cur_pc, then move on to next_pc
    task automatic add_row(input string name, input word_t ins, input logic we,
                           input reg_addr_t rd, input word_t data, input word_t next_pc);
        names.push_back(name);
        instrs.push_back(ins);
        pcs.push_back(cur_pc);
        wes.push_back(we);
        rds.push_back(rd);
        datas.push_back(data);
        if (we && rd != 5'd0) begin
            xr[rd] = data;
        end
        cur_pc = next_pc;
    endtask

    task automatic alu_imm_row(input string name, input logic [2:0] f3, input logic [11:0] imm,
                               input reg_addr_t rs1, input reg_addr_t rd, input word_t exp);
        add_row(name, i_word(imm, rs1, f3, rd, OPC_OP_IMM), 1'b1, rd, exp, cur_pc + 32'd4);
    endtask

    task automatic alu_reg_row(input string name, input logic [6:0] f7, input logic [2:0] f3,
                               input reg_addr_t rs1, input reg_addr_t rs2, input reg_addr_t rd,
                               input word_t exp);
        add_row(name, r_word(f7, rs2, rs1, f3, rd), 1'b1, rd, exp, cur_pc + 32'd4);
    endtask

    // branches retire nothing so only the next pc matters
    task automatic branch_row(input string name, input logic [2:0] f3, input reg_addr_t rs1,
                              input reg_addr_t rs2, input logic [12:0] off);
        word_t next_pc;
        next_pc = branch_taken(f3, xr[rs1], xr[rs2]) ? cur_pc + sign_ext13(off) : cur_pc + 32'd4;
        add_row(name, branch_word(off, rs1, rs2, f3), 1'b0, 5'd0, 32'd0, next_pc);
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        logic [11:0] imm_a;
        logic [11:0] imm_b;
        logic [11:0] imm_c;
        logic [11:0] imm_d;
        logic [4:0]  sh_a;
        logic [4:0]  sh_b;
        rnd = $urandom;
        imm_a = rnd[11:0];
        rnd = $urandom;
        imm_b = rnd[11:0];
        rnd = $urandom;
        imm_c = rnd[11:0];
        rnd = $urandom;
        imm_d = rnd[11:0];
        rnd = $urandom;
        sh_a = rnd[4:0];
        sh_b = rnd[12:8];
        xr[0] = '0;
        cur_pc = START_PC;
        // register-immediate group with random immediates
        alu_imm_row("addi", F3_ADD, imm_a, 5'd0, 5'd1, sign_ext12(imm_a));
        alu_imm_row("addi_chain", F3_ADD, imm_b, 5'd1, 5'd2, xr[1] + sign_ext12(imm_b));
        alu_imm_row("addi_neg", F3_ADD, 12'h800, 5'd0, 5'd7, 32'hffff_f800);
        alu_imm_row("slti", F3_SLT, imm_c, 5'd2, 5'd3,
                    ($signed(xr[2]) < $signed(sign_ext12(imm_c))) ? 32'd1 : 32'd0);
        alu_imm_row("xori", F3_XOR, imm_d, 5'd1, 5'd4, xr[1] ^ sign_ext12(imm_d));
        alu_imm_row("slli", F3_SLL, {7'b0, sh_a}, 5'd4, 5'd5, xr[4] << sh_a);
        alu_imm_row("srai", F3_SR, {7'b0100000, sh_b}, 5'd7, 5'd6,
                    shift_right_arith(xr[7], sh_b));
        // register-register group on the values above
        alu_reg_row("add", 7'b0, F3_ADD, 5'd1, 5'd2, 5'd8, xr[1] + xr[2]);
        alu_reg_row("sub", 7'b0100000, F3_ADD, 5'd1, 5'd7, 5'd9, xr[1] - xr[7]);
        alu_reg_row("slt", 7'b0, F3_SLT, 5'd7, 5'd1, 5'd10,
                    ($signed(xr[7]) < $signed(xr[1])) ? 32'd1 : 32'd0);
        alu_reg_row("sltu", 7'b0, F3_SLTU, 5'd7, 5'd1, 5'd11, (xr[7] < xr[1]) ? 32'd1 : 32'd0);
        alu_reg_row("srl", 7'b0, F3_SR, 5'd7, 5'd5, 5'd12, xr[7] >> xr[5][4:0]);
        alu_reg_row("sra", 7'b0100000, F3_SR, 5'd7, 5'd1, 5'd13,
                    shift_right_arith(xr[7], xr[1][4:0]));
        alu_reg_row("and", 7'b0, F3_AND, 5'd4, 5'd8, 5'd14, xr[4] & xr[8]);
        alu_reg_row("or", 7'b0, F3_OR, 5'd4, 5'd9, 5'd15, xr[4] | xr[9]);
        // write to x0 retires but must not stick
        alu_imm_row("addi_x0", F3_ADD, 12'h7ff, 5'd1, 5'd0, xr[1] + 32'd2047);
        alu_reg_row("x0_read", 7'b0, F3_ADD, 5'd0, 5'd0, 5'd16, 32'd0);
        // upper immediates
        add_row("lui", u_word(20'h12345, 5'd17, OPC_LUI), 1'b1, 5'd17, 32'h1234_5000,
                cur_pc + 32'd4);
        add_row("auipc", u_word(20'hfffff, 5'd18, OPC_AUIPC), 1'b1, 5'd18,
                cur_pc + 32'hffff_f000, cur_pc + 32'd4);
        // x17 is positive and x7 negative
        branch_row("beq_taken", F3_BEQ, 5'd17, 5'd17, 13'd8);
        branch_row("beq_not", F3_BEQ, 5'd17, 5'd7, 13'd8);
        branch_row("bne_taken", F3_BNE, 5'd17, 5'd7, 13'd12);
        branch_row("bne_not", F3_BNE, 5'd17, 5'd17, 13'd12);
        // back 20 bytes
        branch_row("blt_taken", F3_BLT, 5'd7, 5'd17, 13'h1fec);
        branch_row("blt_not", F3_BLT, 5'd17, 5'd7, 13'd16);
        branch_row("bge_taken", F3_BGE, 5'd17, 5'd7, 13'd16);
        branch_row("bge_not", F3_BGE, 5'd7, 5'd17, 13'd16);
        branch_row("bltu_taken", F3_BLTU, 5'd17, 5'd7, 13'd24);
        branch_row("bltu_not", F3_BLTU, 5'd7, 5'd17, 13'd24);
        branch_row("bgeu_taken", F3_BGEU, 5'd7, 5'd17, 13'h1ff0);
        branch_row("bgeu_not", F3_BGEU, 5'd17, 5'd7, 13'd28);
        // jumps link pc + 4
        add_row("jal_fwd", jal_word(21'h40, 5'd19), 1'b1, 5'd19, cur_pc + 32'd4,
                cur_pc + sign_ext21(21'h40));
        add_row("jal_back", jal_word(21'h1fffd0, 5'd20), 1'b1, 5'd20, cur_pc + 32'd4,
                cur_pc + sign_ext21(21'h1fffd0));
        // odd base so the target lsb gets dropped
        alu_imm_row("addi_base", F3_ADD, 12'h301, 5'd0, 5'd22, 32'h0000_0301);
        add_row("jalr", i_word(12'h010, 5'd22, 3'b000, 5'd21, OPC_JALR), 1'b1, 5'd21,
                cur_pc + 32'd4, (xr[22] + sign_ext12(12'h010)) & ~32'd1);
        alu_imm_row("after_jalr", F3_ADD, 12'h001, 5'd21, 5'd23, xr[21] + 32'd1);
    endtask

    // compare tasks for each result type
    task automatic check_word(input string name, input string what, input word_t exp,
                              input word_t act);
        if (act !== exp) begin
            $display("[ERROR] %s %s: expected %h, actual %h", name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            $display("[ERROR] %s retire_rd: expected %0d, actual %0d", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_bit(input string name, input string what, input logic exp,
                             input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s %s: expected %b, actual %b", name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
        end
        $display("test %s: %s", name, (test_errs == 0) ? "ok" : "mismatch");
    endtask

    initial begin
        logic reset_we_seen;
        clk = 1'b0;
        rst_n = 1'b0;
        // addi x1, x0, 1 sits on the bus through reset
        instr = i_word(12'h001, 5'd0, F3_ADD, 5'd1, OPC_OP_IMM);
        table_ready = 1'b0;
        tests_run = 0;
        tests_failed = 0;
        void'($urandom(SEED));
        build_table();
        table_ready = 1'b1;
        reset_we_seen = 1'b0;
        repeat (RESET_CYCLES - 1) begin
            @(posedge clk);
            @(negedge clk);
            reset_we_seen = reset_we_seen | retire_we;
        end
        test_errs = 0;
        check_bit("reset", "retire_we", 1'b0, reset_we_seen);
        report_test("reset");
        for (int i = 0; i < names.size(); i++) begin
            @(posedge clk);
            // released on the fifth edge together with the first fetch
            if (i == 0) begin
                rst_n <= 1'b1;
            end
            instr <= instrs[i];
            @(negedge clk);
            test_errs = 0;
            check_word(names[i], "pc", pcs[i], pc);
            check_bit(names[i], "retire_we", wes[i], retire_we);
            if (wes[i]) begin
                check_reg(names[i], rds[i], retire_rd);
                check_word(names[i], "retire_data", datas[i], retire_data);
            end
            report_test(names[i]);
        end
        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // table length plus reset plus some slack
    initial begin
        int limit;
        wait (table_ready === 1'b1);
        limit = (names.size() + RESET_CYCLES + 1) * CLK_PERIOD + WATCHDOG_MARGIN;
        #(limit);
        $display("timeout: the run did not complete within %0d time units", limit);
        $display("Regression failed");
        $finish;
    end

endmodule

/* cpu_core.f */
common/rv_pkg.sv
hdl/alu.sv
hdl/imm_decoder.sv
hdl/reg_file.sv
hdl/control_unit.sv
hdl/pc_unit.sv
hdl/cpu_core.sv
test/cpu_core_checker.sv
test/cpu_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator from the file list, run, and judge by the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpu_core_tb -f cpu_core.f \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vcpu_core_tb > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }

cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0
